//--- verilog/cdd_pkg.sv
package cdd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// frame geometry
	////////////////////////////////////////////////////////////////////////////

	// status and command frames are both twelve bytes
	localparam int FRAME_BYTES = 12;

	// one byte on the serial link
	typedef logic [7:0] cdd_byte_t;

	// byte 0 sits in the low bits and goes out first
	typedef cdd_byte_t [FRAME_BYTES-1:0] cdd_frame_t;

	// byte position inside a frame, 12..15 are past the end
	typedef logic [3:0] byte_index_t;

	// bit position inside a byte
	typedef logic [2:0] bit_index_t;

	// index of the final byte of a frame
	localparam byte_index_t LAST_INDEX = byte_index_t'(FRAME_BYTES - 1);

	// last bit of a byte, lsb goes first
	localparam bit_index_t LAST_BIT = 3'd7;

	////////////////////////////////////////////////////////////////////////////
	// default timing, in clk_sys cycles
	////////////////////////////////////////////////////////////////////////////

	// status capture to first request
	localparam int DEFAULT_START_HOLD = 15;

	// end of one byte to the request for the next
	// roughly what the drive needs to prepare the following byte
	localparam int DEFAULT_BYTE_GAP = 1023;

endpackage

//--- verilog/cdd_status_capture.sv
`timescale 1ns/1ps

module cdd_status_capture #(
	parameter int start_hold = cdd_pkg::DEFAULT_START_HOLD
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cdd_pkg::cdd_frame_t  status_frame,
	input  logic                 status_toggle,
	input  cdd_pkg::byte_index_t status_index,
	output cdd_pkg::cdd_byte_t   status_byte,
	output logic                 exchange_start
);
	import cdd_pkg::*;

	localparam int HOLD_W = $clog2(start_hold + 1);

	// last toggle value taken from the host
	logic toggle_seen;
	logic new_frame;

	// copy of the status frame for the whole exchange
	cdd_frame_t frame_q;

	// hold countdown, zero when idle
	logic [HOLD_W-1:0] hold_count;

	// host owns the frame, a changed toggle marks a fresh one
	assign new_frame = (status_toggle != toggle_seen);

	////////////////////////////////////////////////////////////////////////////
	// toggle tracking and start hold
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_seen    <= 1'b0;
			hold_count     <= '0;
			exchange_start <= 1'b0;
		end else begin
			exchange_start <= 1'b0;
			if (new_frame) begin
				// a newer frame restarts the hold
				toggle_seen <= status_toggle;
				hold_count  <= HOLD_W'(start_hold);
			end else if (hold_count != '0) begin
				hold_count     <= hold_count - 1'b1;
				exchange_start <= (hold_count == HOLD_W'(1));
			end
		end
	end

	// frame is stable while the toggle changes
	always_ff @(posedge clk_sys) begin
		if (new_frame) begin
			frame_q <= status_frame;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// byte select for the exchange
	////////////////////////////////////////////////////////////////////////////

	// past the last byte the drive gets zeros
	always_comb begin
		if (status_index < FRAME_BYTES) begin
			status_byte = frame_q[status_index];
		end else begin
			status_byte = '0;
		end
	end

endmodule

//--- verilog/cdd_byte_exchange.sv
`timescale 1ns/1ps

module cdd_byte_exchange #(
	parameter int byte_gap = cdd_pkg::DEFAULT_BYTE_GAP
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 exchange_start,
	input  cdd_pkg::cdd_byte_t   status_byte,
	input  logic                 comclk,
	input  logic                 hdata,
	output cdd_pkg::byte_index_t status_index,
	output logic                 cdata,
	output logic                 comreq_n,
	output logic                 comsync_n,
	output cdd_pkg::cdd_byte_t   host_byte,
	output cdd_pkg::byte_index_t byte_index,
	output logic                 byte_valid,
	output logic                 frame_last
);
	import cdd_pkg::*;

	localparam int REQ_W = $clog2(byte_gap + 1);

	// comclk history for edge detection
	logic comclk_q;
	logic comclk_rise;
	logic comclk_fall;

	// frame in progress, edges are ignored otherwise
	logic frame_active;

	// position in the frame and in the byte
	byte_index_t byte_count;
	bit_index_t  bit_count;

	// status bits still to send, host bits collected so far
	cdd_byte_t tx_shift;
	cdd_byte_t rx_shift;

	// countdown to the next comreq_n, zero when idle
	logic [REQ_W-1:0] req_count;

	assign comclk_rise = frame_active && comclk && !comclk_q;
	assign comclk_fall = frame_active && !comclk && comclk_q;

	// byte 0 at start, the following byte otherwise
	assign status_index = exchange_start ? byte_index_t'(0) : byte_count + 4'd1;

	// completed byte toward command assembly
	assign host_byte  = rx_shift;
	assign byte_index = byte_count;
	assign frame_last = byte_valid && (byte_count == LAST_INDEX);

	// drive idles with comclk high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comclk_q <= 1'b1;
		end else begin
			comclk_q <= comclk;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// receive side, host bit on every rising comclk
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bit_count  <= '0;
			byte_valid <= 1'b0;
		end else if (exchange_start) begin
			bit_count  <= '0;
			byte_valid <= 1'b0;
		end else if (comclk_rise) begin
			bit_count  <= bit_count + 3'd1;
			byte_valid <= (bit_count == LAST_BIT);
		end else begin
			byte_valid <= 1'b0;
		end
	end

	// lsb first, so new bits enter at the top
	always_ff @(posedge clk_sys) begin
		if (comclk_rise) begin
			rx_shift <= {hdata, rx_shift[7:1]};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// transmit side and byte sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			frame_active <= 1'b0;
			byte_count   <= '0;
			cdata        <= 1'b0;
			comreq_n     <= 1'b1;
			comsync_n    <= 1'b1;
			req_count    <= '0;
		end else begin
			// request goes out when the countdown expires
			if (req_count != '0) begin
				req_count <= req_count - 1'b1;
				if (req_count == REQ_W'(1)) begin
					comreq_n <= 1'b0;
				end
			end

			if (exchange_start) begin
				// also taken mid frame, the exchange restarts at byte 0
				frame_active <= 1'b1;
				byte_count   <= '0;
				tx_shift     <= status_byte;
				comsync_n    <= 1'b0;
				comreq_n     <= 1'b1;
				req_count    <= REQ_W'(1);
			end else if (byte_valid) begin
				comsync_n <= 1'b1;
				tx_shift  <= status_byte;
				if (byte_count == LAST_INDEX) begin
					frame_active <= 1'b0;
				end else begin
					byte_count <= byte_count + 4'd1;
					req_count  <= REQ_W'(byte_gap);
				end
			end else if (comclk_fall) begin
				{tx_shift, cdata} <= {1'b0, tx_shift};
			end else if (comclk_rise) begin
				// drive has taken the request
				comreq_n <= 1'b1;
			end
		end
	end

endmodule

//--- verilog/cdd_command_assembly.sv
`timescale 1ns/1ps

module cdd_command_assembly (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  cdd_pkg::cdd_byte_t   host_byte,
	input  cdd_pkg::byte_index_t byte_index,
	input  logic                 byte_valid,
	input  logic                 frame_last,
	output cdd_pkg::cdd_frame_t  command_frame,
	output logic                 command_toggle
);
	import cdd_pkg::*;

	// bytes of the frame currently being received
	cdd_frame_t staging;

	// staging with the incoming byte already in place
	cdd_frame_t frame_next;

	////////////////////////////////////////////////////////////////////////////
	// staging
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		frame_next = staging;
		if (byte_index < FRAME_BYTES) begin
			frame_next[byte_index] = host_byte;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_valid) begin
			staging <= frame_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// publish to the host
	////////////////////////////////////////////////////////////////////////////

	// no back-pressure, an unread frame is simply replaced
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			command_frame  <= '0;
			command_toggle <= 1'b0;
		end else if (byte_valid && frame_last) begin
			command_frame  <= frame_next;
			command_toggle <= !command_toggle;
		end
	end

endmodule

//--- verilog/cdd_link.sv
`timescale 1ns/1ps

module cdd_link #(
	parameter int start_hold = cdd_pkg::DEFAULT_START_HOLD,
	parameter int byte_gap   = cdd_pkg::DEFAULT_BYTE_GAP
) (
	input  logic                clk_sys,
	input  logic                reset,

	// host side
	input  cdd_pkg::cdd_frame_t status_frame,
	input  logic                status_toggle,
	output cdd_pkg::cdd_frame_t command_frame,
	output logic                command_toggle,

	// drive side
	input  logic                comclk,
	input  logic                hdata,
	output logic                cdata,
	output logic                comreq_n,
	output logic                comsync_n
);
	import cdd_pkg::*;

	// capture to exchange
	logic        exchange_start;
	byte_index_t status_index;
	cdd_byte_t   status_byte;

	// exchange to assembly
	cdd_byte_t   host_byte;
	byte_index_t byte_index;
	logic        byte_valid;
	logic        frame_last;

	cdd_status_capture #(
		.start_hold(start_hold)
	) i_cdd_status_capture (
		.clk_sys(clk_sys),
		.reset(reset),
		.status_frame(status_frame),
		.status_toggle(status_toggle),
		.status_index(status_index),
		.status_byte(status_byte),
		.exchange_start(exchange_start)
	);

	cdd_byte_exchange #(
		.byte_gap(byte_gap)
	) i_cdd_byte_exchange (
		.clk_sys(clk_sys),
		.reset(reset),
		.exchange_start(exchange_start),
		.status_byte(status_byte),
		.comclk(comclk),
		.hdata(hdata),
		.status_index(status_index),
		.cdata(cdata),
		.comreq_n(comreq_n),
		.comsync_n(comsync_n),
		.host_byte(host_byte),
		.byte_index(byte_index),
		.byte_valid(byte_valid),
		.frame_last(frame_last)
	);

	cdd_command_assembly i_cdd_command_assembly (
		.clk_sys(clk_sys),
		.reset(reset),
		.host_byte(host_byte),
		.byte_index(byte_index),
		.byte_valid(byte_valid),
		.frame_last(frame_last),
		.command_frame(command_frame),
		.command_toggle(command_toggle)
	);

endmodule

//--- verification/cdd_link_tb.sv
`timescale 1ns/1ps

module cdd_link_tb;
	import cdd_pkg::*;

	localparam int START_HOLD = 15;
	localparam int BYTE_GAP = 40;

	// full frames over the whole run with the restart test as two
	localparam int TEST_FRAMES = 8;
	localparam int CYCLE_LIMIT = TEST_FRAMES * FRAME_BYTES * (BYTE_GAP + 8 * 8 + 10) + 200;

	logic       clk_sys;
	logic       reset;
	cdd_frame_t status_frame;
	logic       status_toggle;
	cdd_frame_t command_frame;
	logic       command_toggle;
	logic       comclk;
	logic       hdata;
	logic       cdata;
	logic       comreq_n;
	logic       comsync_n;

	int   cycle_count = 0;
	int   flip_count = 0;
	logic toggle_last = 1'b0;

	cdd_link #(
		.start_hold(START_HOLD),
		.byte_gap(BYTE_GAP)
	) i_cdd_link (
		.clk_sys(clk_sys),
		.reset(reset),
		.status_frame(status_frame),
		.status_toggle(status_toggle),
		.command_frame(command_frame),
		.command_toggle(command_toggle),
		.comclk(comclk),
		.hdata(hdata),
		.cdata(cdata),
		.comreq_n(comreq_n),
		.comsync_n(comsync_n)
	);

	always #20 clk_sys = !clk_sys;

	// count command_toggle flips where the value is settled
	always @(negedge clk_sys) begin
		if (command_toggle !== toggle_last) begin
			flip_count  = flip_count + 1;
			toggle_last = command_toggle;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [95:0] actual,
			input logic [95:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			abort_run();
		end
	endtask

	function automatic cdd_frame_t pattern_frame(input cdd_byte_t base);
		cdd_frame_t f;
		int k;
		for (k = 0; k < FRAME_BYTES; k++) begin
			f[k] = base ^ cdd_byte_t'(k * 37);
		end
		return f;
	endfunction

	function automatic cdd_frame_t random_frame();
		cdd_frame_t f;
		int k;
		for (k = 0; k < FRAME_BYTES; k++) begin
			f[k] = cdd_byte_t'($urandom);
		end
		return f;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// host and drive models
	////////////////////////////////////////////////////////////////////////////

	// frame settles one cycle before the toggle moves
	task automatic send_status(input cdd_frame_t f);
		status_frame = f;
		@(negedge clk_sys);
		status_toggle = !status_toggle;
		@(negedge clk_sys);
	endtask

	task automatic wait_request();
		while (comreq_n !== 1'b0) begin
			@(negedge clk_sys);
		end
	endtask

	// command frame is published when command_toggle moves
	task automatic wait_command(input int flips_before);
		while (flip_count == flips_before) begin
			@(negedge clk_sys);
		end
	endtask

	// 4 cycles low and 4 cycles high per bit with lsb first
	task automatic drive_byte(input int index, input cdd_byte_t host_value,
			output cdd_byte_t status_value);
		int i;
		status_value = '0;
		wait_request();
		for (i = 0; i < 8; i++) begin
			comclk = 1'b0;
			repeat (3) @(negedge clk_sys);
			status_value[i] = cdata;
			check_value("comsync_n", comsync_n, (index == 0) ? 1'b0 : 1'b1);
			if (i == 0) begin
				check_value("comreq_n", comreq_n, 1'b0);
			end
			hdata = host_value[i];
			@(negedge clk_sys);
			comclk = 1'b1;
			repeat (4) @(negedge clk_sys);
			// request is withdrawn on the first rising comclk
			if (i == 0) begin
				check_value("comreq_n", comreq_n, 1'b1);
			end
		end
	endtask

	task automatic drive_frame(input cdd_frame_t host, input int count, output cdd_frame_t seen);
		cdd_byte_t value;
		int k;
		seen = '0;
		for (k = 0; k < count; k++) begin
			drive_byte(k, host[k], value);
			seen[k] = value;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		check_value("comreq_n", comreq_n, 1'b1);
		check_value("comsync_n", comsync_n, 1'b1);
		check_value("cdata", cdata, 1'b0);
		check_value("command_toggle", command_toggle, 1'b0);
		check_value("command_frame", command_frame, '0);
	endtask

	task automatic test_status_on_wire();
		cdd_frame_t status;
		cdd_frame_t seen;
		status = pattern_frame(8'h5a);
		send_status(status);
		drive_frame('0, FRAME_BYTES, seen);
		check_value("cdata frame", seen, status);
		check_value("comsync_n", comsync_n, 1'b1);
	endtask

	task automatic test_command_assembly();
		cdd_frame_t host;
		cdd_frame_t seen;
		int flips;
		host = pattern_frame(8'hc3);
		flips = flip_count;
		send_status(pattern_frame(8'h0f));
		drive_frame(host, FRAME_BYTES, seen);
		wait_command(flips);
		check_value("command_frame", command_frame, host);
		check_value("command_toggle flips", flip_count - flips, 1);
	endtask

	task automatic test_request_protocol();
		cdd_frame_t seen;
		int wait_cycles;
		int n;
		send_status(pattern_frame(8'h96));
		// send_status already spent one cycle after the toggle
		wait_cycles = 1;
		while (comreq_n !== 1'b0) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		check_value("first request delay", wait_cycles, START_HOLD + 3);
		check_value("comsync_n", comsync_n, 1'b0);
		drive_frame(pattern_frame(8'h21), FRAME_BYTES, seen);
		// no request after byte 11
		for (n = 0; n < 3 * BYTE_GAP; n++) begin
			@(negedge clk_sys);
			check_value("comreq_n", comreq_n, 1'b1);
		end
	endtask

	task automatic test_restart();
		cdd_frame_t status_a;
		cdd_frame_t status_b;
		cdd_frame_t host_b;
		cdd_frame_t seen;
		int flips;
		status_a = pattern_frame(8'h33);
		status_b = pattern_frame(8'he4);
		host_b = pattern_frame(8'h78);
		flips = flip_count;
		send_status(status_a);
		drive_frame(pattern_frame(8'hff), 5, seen);
		check_value("cdata bytes 0-4", seen[4:0], status_a[4:0]);
		send_status(status_b);
		drive_frame(host_b, FRAME_BYTES, seen);
		check_value("cdata frame", seen, status_b);
		wait_command(flips);
		check_value("command_frame", command_frame, host_b);
		check_value("command_toggle flips", flip_count - flips, 1);
	endtask

	task automatic test_random_frames();
		cdd_frame_t status;
		cdd_frame_t host;
		cdd_frame_t seen;
		int flips;
		int r;
		for (r = 0; r < 3; r++) begin
			status = random_frame();
			host = random_frame();
			flips = flip_count;
			send_status(status);
			drive_frame(host, FRAME_BYTES, seen);
			check_value("cdata frame", seen, status);
			wait_command(flips);
			check_value("command_frame", command_frame, host);
			check_value("command_toggle flips", flip_count - flips, 1);
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		status_frame = '0;
		status_toggle = 1'b0;
		comclk = 1'b1;
		hdata = 1'b0;
		void'($urandom(52));
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		test_reset_state();
		test_status_on_wire();
		test_command_assembly();
		test_request_protocol();
		test_restart();
		test_random_frames();
		$display("No errors");
		$finish;
	end

endmodule

//--- cdd_link.f
verilog/cdd_pkg.sv
verilog/cdd_status_capture.sv
verilog/cdd_byte_exchange.sv
verilog/cdd_command_assembly.sv
verilog/cdd_link.sv
verification/cdd_link_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = cdd_link_tb
FILELIST = cdd_link.f
BUILD    = obj_dir

.PHONY: simulate clean

# $fatal in the testbench gives a nonzero exit status
simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
